/* Bender.yml */
package:
  name: obstacle

sources:
  - files:
      - hdl/obstacle_pkg.sv
      - hdl/spawn_scheduler.sv
      - hdl/spawn_queue.sv
      - hdl/obstacle_mover.sv
      - hdl/obstacle_top.sv
  - target: test
    files:
      - tb/tb_clkgen.sv
      - tb/obstacle_tb.sv

/* compile.f */
hdl/obstacle_pkg.sv
hdl/spawn_scheduler.sv
hdl/spawn_queue.sv
hdl/obstacle_mover.sv
hdl/obstacle_top.sv
tb/tb_clkgen.sv
tb/obstacle_tb.sv

/* hdl/obstacle_mover.sv */
// obstacle mover
// launches one queued obstacle past the right edge and slides it left each frame
`timescale 1ns/1ps
`default_nettype none

module obstacle_mover (
   input  wire logic                          i_clk,
   input  wire logic                          i_rst,
   input  wire logic                          i_ani_stb,
   input  wire logic                          i_animate,
   input  wire logic                          i_pop_valid,   // queue not empty
   input  wire obstacle_pkg::obstacle_desc_t  i_pop_desc,    // queue head
   output logic                               o_pop_ready,   // idle on a frame
   output logic                               o_active,      // obstacle on screen
   output obstacle_pkg::obstacle_box_t        o_box
);

   logic                                      frame;
   logic                                      pop_en;
   logic                                      gone;      // next step is off the left edge
   logic signed [obstacle_pkg::coord_w-1:0]   x_pos;     // horizontal centre
   logic signed [obstacle_pkg::coord_w-1:0]   x_next;
   logic signed [obstacle_pkg::coord_w-1:0]   half_h_s;  // half height as a coordinate
   obstacle_pkg::obstacle_desc_t              desc_q;    // shape of the live obstacle
   obstacle_pkg::obstacle_box_t               box;

   assign frame       = i_ani_stb & i_animate;
   assign o_pop_ready = frame & ~o_active;                // only take a new one when idle
   assign pop_en      = o_pop_ready & i_pop_valid;
   assign x_next      = x_pos - obstacle_pkg::obstacle_vel;
   assign gone        = (x_next <= -obstacle_pkg::obstacle_half_w);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_active <= 1'b0;
      end else if (pop_en) begin
         o_active <= 1'b1;                                // visible one cycle after the pop
      end else if (frame && o_active && gone) begin
         o_active <= 1'b0;                                // retire at this frame
      end
   end

   always_ff @(posedge i_clk) begin
      if (pop_en) begin
         x_pos  <= obstacle_pkg::d_width + obstacle_pkg::obstacle_half_w;   // just off screen
         desc_q <= i_pop_desc;
      end else if (frame && o_active) begin
         x_pos  <= x_next;
      end
   end

   assign half_h_s = signed'(obstacle_pkg::coord_w'(desc_q.half_h));

   always_comb begin
      box.x1 = x_pos - obstacle_pkg::obstacle_half_w;
      box.x2 = x_pos + obstacle_pkg::obstacle_half_w;
      box.y1 = signed'(desc_q.y_centre) - half_h_s;
      box.y2 = signed'(desc_q.y_centre) + half_h_s;
   end

   assign o_box = o_active ? box : '0;                    // empty box while idle

   // edges stay ordered for as long as something is on screen
   a_box_order: assert property (@(posedge i_clk) disable iff (i_rst)
      o_active |-> o_box.x1 < o_box.x2)
      else $error("obstacle_mover: left edge not below right edge");

   // a pop makes the obstacle live and blocks further pops while it lasts
   a_one_live: assert property (@(posedge i_clk) disable iff (i_rst)
      pop_en |=> o_active && !pop_en)
      else $error("obstacle_mover: pop while an obstacle is active");

endmodule

`default_nettype wire

/* hdl/obstacle_pkg.sv */
// obstacle subsystem shared definitions
// screen geometry, obstacle shapes, spawn generator setup, descriptor and box types
`default_nettype none

package obstacle_pkg;

   // widths
   localparam int coord_w     = 12;                 // screen coordinate width
   localparam int half_h_w    = 8;                  // half height field width
   localparam int lfsr_w      = 16;                 // generator width
   localparam int rnd_w       = 4;                  // each random offset is 0..15
   localparam int gap_w       = 6;                  // wait counter, holds up to gap_min + 30

   // screen geometry
   localparam logic signed [coord_w-1:0] d_width = 12'sd640;   // visible width
   localparam logic [coord_w-1:0]        floor_y = 12'd400;    // ground line

   // obstacle shape and motion
   localparam logic signed [coord_w-1:0] obstacle_half_w   = 12'sd12;  // same for all kinds
   localparam logic signed [coord_w-1:0] obstacle_vel      = 12'sd8;   // px left per frame
   localparam logic [half_h_w-1:0]       cactus_half_h_min = 8'd20;    // plus 0..15
   localparam logic [half_h_w-1:0]       bird_half_h       = 8'd10;    // birds never vary
   localparam logic [coord_w-1:0]        bird_y_max        = 12'd360;  // minus 4 * 0..15

   // frames between spawns is gap_min + 2 * 0..15
   localparam logic [gap_w-1:0] gap_min = 6'd24;

   // galois generator for x^16+x^14+x^13+x^11+1 in right shift form
   localparam logic [lfsr_w-1:0] lfsr_seed = 16'hace1;
   localparam logic [lfsr_w-1:0] lfsr_taps = 16'hb400;

   // spawn queue sizing
   localparam int queue_depth = 4;
   localparam int queue_ptr_w = $clog2(queue_depth);
   localparam int queue_cnt_w = queue_ptr_w + 1;    // count must reach queue_depth
   localparam logic [queue_ptr_w-1:0] queue_last = queue_ptr_w'(queue_depth - 1);
   localparam logic [queue_cnt_w-1:0] queue_full = queue_cnt_w'(queue_depth);

   // obstacle kinds
   localparam logic kind_cactus = 1'b0;
   localparam logic kind_bird   = 1'b1;

   // 21 bit request the scheduler hands to the mover
   typedef struct packed {
      logic                kind;       // 0 cactus, 1 bird
      logic [coord_w-1:0]  y_centre;   // vertical centre
      logic [half_h_w-1:0] half_h;     // half height
   } obstacle_desc_t;

   // 48 bit bounding box of the obstacle on screen
   typedef struct packed {
      logic signed [coord_w-1:0] x1;   // left
      logic signed [coord_w-1:0] x2;   // right
      logic signed [coord_w-1:0] y1;   // top
      logic signed [coord_w-1:0] y2;   // bottom
   } obstacle_box_t;

endpackage

`default_nettype wire

/* hdl/obstacle_top.sv */
// obstacle subsystem top
// spawn scheduler feeds the queue, queue feeds the mover that reports the box
`timescale 1ns/1ps
`default_nettype none

module obstacle_top (
   input  wire logic                    i_clk,
   input  wire logic                    i_rst,
   input  wire logic                    i_ani_stb,
   input  wire logic                    i_animate,
   input  wire logic                    i_grace,
   output logic                         o_active,
   output obstacle_pkg::obstacle_box_t  o_box
);

   logic                          push_valid;   // scheduler request
   logic                          push_ready;   // queue not full
   obstacle_pkg::obstacle_desc_t  push_desc;
   logic                          pop_valid;    // queue not empty
   logic                          pop_ready;    // mover idle on a frame
   obstacle_pkg::obstacle_desc_t  pop_desc;

   spawn_scheduler u_sched (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_ani_stb    (i_ani_stb),
      .i_animate    (i_animate),
      .i_grace      (i_grace),
      .i_push_ready (push_ready),
      .o_push_valid (push_valid),
      .o_push_desc  (push_desc)
   );

   spawn_queue #(
      .payload_t (obstacle_pkg::obstacle_desc_t)
   ) u_queue (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_push_valid (push_valid),
      .i_push_data  (push_desc),
      .i_pop_ready  (pop_ready),
      .o_push_ready (push_ready),
      .o_pop_valid  (pop_valid),
      .o_pop_data   (pop_desc)
   );

   obstacle_mover u_mover (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_ani_stb   (i_ani_stb),
      .i_animate   (i_animate),
      .i_pop_valid (pop_valid),
      .i_pop_desc  (pop_desc),
      .o_pop_ready (pop_ready),
      .o_active    (o_active),
      .o_box       (o_box)
   );

endmodule

`default_nettype wire

/* hdl/spawn_queue.sv */
// spawn queue
// small circular FIFO between scheduler and mover, head is read combinationally
`timescale 1ns/1ps
`default_nettype none

module spawn_queue #(
   parameter type payload_t = obstacle_pkg::obstacle_desc_t
) (
   input  wire logic     i_clk,
   input  wire logic     i_rst,
   input  wire logic     i_push_valid,
   input  wire payload_t i_push_data,
   input  wire logic     i_pop_ready,
   output logic          o_push_ready,   // not full
   output logic          o_pop_valid,    // not empty
   output payload_t      o_pop_data      // head entry
);

   payload_t                              mem [obstacle_pkg::queue_depth];
   logic [obstacle_pkg::queue_ptr_w-1:0]  wr_ptr;
   logic [obstacle_pkg::queue_ptr_w-1:0]  rd_ptr;
   logic [obstacle_pkg::queue_cnt_w-1:0]  count;    // occupancy
   logic                                  push_en;
   logic                                  pop_en;

   assign o_push_ready = (count != obstacle_pkg::queue_full);
   assign o_pop_valid  = (count != '0);
   assign o_pop_data   = mem[rd_ptr];
   assign push_en      = i_push_valid & o_push_ready;
   assign pop_en       = i_pop_ready & o_pop_valid;

   always_ff @(posedge i_clk) begin
      if (push_en) begin
         mem[wr_ptr] <= i_push_data;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_en) begin
            wr_ptr <= (wr_ptr == obstacle_pkg::queue_last) ? '0 : wr_ptr + 1'b1;
         end
         if (pop_en) begin
            rd_ptr <= (rd_ptr == obstacle_pkg::queue_last) ? '0 : rd_ptr + 1'b1;
         end
         case ({push_en, pop_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;           // both or neither
         endcase
      end
   end

   // a push offered while full is dropped and the write side does not move
   a_no_push_full: assert property (@(posedge i_clk) disable iff (i_rst)
      i_push_valid && !o_push_ready |=> $stable(wr_ptr))
      else $error("spawn_queue: write pointer moved on a push while full");

   // nothing is read out of an empty queue
   a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_rst)
      !o_pop_valid |=> $stable(rd_ptr))
      else $error("spawn_queue: read pointer moved while empty");

endmodule

`default_nettype wire

/* hdl/spawn_scheduler.sv */
// spawn scheduler
// runs the obstacle generator and wait timer, pushes one descriptor per expired wait
`timescale 1ns/1ps
`default_nettype none

module spawn_scheduler (
   input  wire logic                    i_clk,
   input  wire logic                    i_rst,
   input  wire logic                    i_ani_stb,     // animation strobe
   input  wire logic                    i_animate,     // motion enable
   input  wire logic                    i_grace,       // hold the wait timer
   input  wire logic                    i_push_ready,  // queue has room
   output logic                         o_push_valid,  // one cycle after a due frame
   output obstacle_pkg::obstacle_desc_t o_push_desc
);

   logic                                 frame;        // animation frame this cycle
   logic                                 push_done;    // queue took the descriptor
   logic                                 spawn_due;    // frame seen with wait expired
   logic [obstacle_pkg::lfsr_w-1:0]      lfsr;
   logic [obstacle_pkg::lfsr_w-1:0]      lfsr_next;
   logic [obstacle_pkg::gap_w-1:0]       wait_cnt;     // frames left before next spawn
   logic [obstacle_pkg::rnd_w-1:0]       shape_off;    // height or altitude offset
   logic [obstacle_pkg::rnd_w-1:0]       gap_off;      // kept until the push lands
   obstacle_pkg::obstacle_desc_t         desc_new;     // built from the current value

   assign frame     = i_ani_stb & i_animate;
   assign push_done = o_push_valid & i_push_ready;
   // back-to-back frames must not see the stale zero right after a reload
   assign spawn_due = frame & (wait_cnt == '0) & ~push_done;

   // right shift galois step
   assign lfsr_next = (lfsr >> 1) ^ (lfsr[0] ? obstacle_pkg::lfsr_taps : '0);
   assign shape_off = lfsr[obstacle_pkg::rnd_w-1:0];

   always_comb begin
      desc_new.kind = lfsr[0];                            // low bit picks the kind
      if (lfsr[0] == obstacle_pkg::kind_bird) begin
         desc_new.half_h   = obstacle_pkg::bird_half_h;
         desc_new.y_centre = obstacle_pkg::bird_y_max
                           - obstacle_pkg::coord_w'({shape_off, 2'b00});   // 0..60 higher
      end else begin
         desc_new.half_h   = obstacle_pkg::cactus_half_h_min
                           + obstacle_pkg::half_h_w'(shape_off);           // 20..35
         desc_new.y_centre = obstacle_pkg::floor_y
                           - obstacle_pkg::coord_w'(desc_new.half_h);      // sits on floor
      end
   end

   // generator advances on every frame, grace or not
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         lfsr <= obstacle_pkg::lfsr_seed;
      end else if (frame) begin
         lfsr <= lfsr_next;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wait_cnt     <= obstacle_pkg::gap_min;            // first spawn needs a full gap
         o_push_valid <= 1'b0;
      end else begin
         o_push_valid <= spawn_due;                        // single cycle request
         if (push_done) begin
            wait_cnt <= obstacle_pkg::gap_min
                      + obstacle_pkg::gap_w'({gap_off, 1'b0});   // 24..54 frames
         end else if (frame && !i_grace && wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;                   // stops at zero
         end
         // a refused push leaves wait_cnt at zero, so the next frame retries
      end
   end

   // payload of the request, taken from the frame's generator value
   always_ff @(posedge i_clk) begin
      if (spawn_due) begin
         o_push_desc <= desc_new;
         gap_off     <= lfsr[2*obstacle_pkg::rnd_w-1:obstacle_pkg::rnd_w];   // bits 7:4
      end
   end

endmodule

`default_nettype wire

/* tb/obstacle_golden.txt */
// code count grace animate | expected active x1 x2 y1 y2 after the last strobe, all hex
// codes 1 reset 2 bird 3 motion 4 pause 5 grace 6 cactus 7 retire 8 back-pressure
1 01 0 1 0 000 000 000 000
1 17 0 1 0 000 000 000 000
1 01 0 1 0 000 000 000 000
2 01 0 1 1 280 298 132 146
3 01 0 1 1 278 290 132 146
4 03 0 0 1 278 290 132 146
3 0a 0 1 1 228 240 132 146
4 02 0 0 1 228 240 132 146
3 17 0 1 1 170 188 132 146
5 05 1 1 1 148 160 132 146
3 2a 0 1 1 ff8 010 132 146
7 01 0 1 1 ff0 008 132 146
7 01 0 1 0 000 000 000 000
6 01 0 1 1 280 298 14c 190
3 32 0 1 1 0f0 108 14c 190
7 20 0 1 1 ff0 008 14c 190
7 01 0 1 0 000 000 000 000
5 01 0 1 1 280 298 122 136
8 52 0 1 1 ff0 008 122 136
8 01 0 1 0 000 000 000 000
8 01 0 1 1 280 298 150 190
4 04 0 0 1 280 298 150 190
8 28 0 1 1 140 158 150 190
8 2a 0 1 1 ff0 008 150 190
8 01 0 1 0 000 000 000 000
8 01 0 1 1 280 298 15a 16e
8 05 0 1 1 258 270 15a 16e

/* tb/obstacle_tb.sv */
// obstacle subsystem testbench
// replays frame stimulus from the golden file and checks active flag and box edges
`timescale 1ns/1ps
`default_nettype none

module obstacle_tb;

   localparam int max_lines      = 40;
   localparam int words_per_line = 9;     // code count grace animate active x1 x2 y1 y2

   logic                        i_clk;
   logic                        i_rst;
   logic                        i_ani_stb;
   logic                        i_animate;
   logic                        i_grace;
   logic                        o_active;
   obstacle_pkg::obstacle_box_t o_box;

   logic [15:0] gold [max_lines*words_per_line];
   integer      seed;
   int          errors      = 0;
   int          checks      = 0;
   int          n_lines     = 0;
   int          total_stb   = 0;      // strobes over all lines
   int          cycle_limit = 0;
   int          cycles      = 0;

   tb_clkgen clkgen0 (
      .o_clk (i_clk),
      .o_rst (i_rst)
   );

   obstacle_top dut0 (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_ani_stb (i_ani_stb),
      .i_animate (i_animate),
      .i_grace   (i_grace),
      .o_active  (o_active),
      .o_box     (o_box)
   );

   function automatic string test_name(input logic [15:0] code);
      case (code)
         16'h1:   return "reset";
         16'h2:   return "bird_spawn";
         16'h3:   return "motion";
         16'h4:   return "pause";
         16'h5:   return "grace";
         16'h6:   return "cactus_spawn";
         16'h7:   return "retire";
         16'h8:   return "back_pressure";
         default: return "unknown";
      endcase
   endfunction

   // one strobe 2..5 clocks after the previous one, inputs moved 2 ns after the edge
   task automatic drive_frame(input logic grace, input logic animate);
      int gap;
      gap = 2 + ($unsigned($random(seed)) % 4);
      repeat (gap) @(posedge i_clk);
      #2;
      i_ani_stb = 1'b1;
      i_animate = animate;
      i_grace   = grace;
      @(posedge i_clk);
      #2;
      i_ani_stb = 1'b0;                // outputs settled from this edge on
      i_grace   = 1'b0;
   endtask

   task automatic check_value(input string test, input string what, input int exp,
                              input int act);
      checks++;
      if (exp != act) begin
         errors++;
         $display("ERROR %s %s expected %0d actual %0d", test, what, exp, act);
      end
   endtask

   task automatic check_line(input int base);
      string name;
      name = test_name(gold[base]);
      if ($isunknown({o_active, o_box})) begin
         errors++;
         $display("outputs unknown after golden line %0d (%s)", base / words_per_line, name);
      end
      check_value(name, "active", int'(gold[base+4][0]), int'(o_active));
      check_value(name, "x1", int'($signed(gold[base+5][11:0])), int'(o_box.x1));
      check_value(name, "x2", int'($signed(gold[base+6][11:0])), int'(o_box.x2));
      check_value(name, "y1", int'($signed(gold[base+7][11:0])), int'(o_box.y1));
      check_value(name, "y2", int'($signed(gold[base+8][11:0])), int'(o_box.y2));
   endtask

   // cycle watchdog, limit follows the number of strobes in the file
   always @(posedge i_clk) begin
      cycles = cycles + 1;
      if (cycle_limit != 0 && cycles >= cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("tests failed");
         $finish;
      end
   end

   initial begin
      int base;
      i_ani_stb = 1'b0;
      i_animate = 1'b0;
      i_grace   = 1'b0;
      seed      = 32'hcba1;
      for (int i = 0; i < max_lines * words_per_line; i++) begin
         gold[i] = 16'hffff;            // end marker where the file stops
      end
      $readmemh("tb/obstacle_golden.txt", gold);
      while (n_lines < max_lines && gold[n_lines*words_per_line] != 16'hffff) begin
         total_stb += int'(gold[n_lines*words_per_line+1]);
         n_lines++;
      end
      if (n_lines == 0) begin
         errors++;
         $display("golden file missing or holds no stimulus lines");
      end
      cycle_limit = total_stb * 6 + 100;

      @(negedge i_rst);
      for (int ln = 0; ln < n_lines; ln++) begin
         base = ln * words_per_line;
         repeat (int'(gold[base+1])) drive_frame(gold[base+2][0], gold[base+3][0]);
         check_line(base);
      end

      $display("lines %0d checks %0d errors %0d", n_lines, checks, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb/tb_clkgen.sv */
// testbench clock and reset source
// 20 ns clock, synchronous reset held high for the first 5 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
   output logic o_clk,
   output logic o_rst
);

   initial begin
      o_clk = 1'b0;
      forever #10 o_clk = ~o_clk;      // 50 MHz
   end

   initial begin
      o_rst = 1'b1;
      repeat (5) @(posedge o_clk);
      #2 o_rst = 1'b0;                 // released just after the edge like other inputs
   end

endmodule

`default_nettype wire
